// File: arm_mul.f
+incdir+rtl
+incdir+testbench
rtl/arm_mul_pkg.sv
rtl/mul_cmd_reg.sv
rtl/booth_radix2_core.sv
rtl/mul_accumulate_flags.sv
rtl/arm_mul_unit.sv
testbench/arm_mul_tb.sv

// File: Makefile
# Verilator build and run for the multiply unit testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= arm_mul_tb
FILELIST  ?= arm_mul.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/arm_mul_ref.svh
`ifndef ARM_MUL_REF_SVH
`define ARM_MUL_REF_SVH

// expected result of one multiply command, worked out with full double-word
// arithmetic straight from the architectural definition of each command
function automatic void ref_mul(
    input  mul_op_e op,
    input  word_t   a,
    input  word_t   b,
    input  word_t   acc_hi,
    input  word_t   acc_lo,
    output word_t   q_hi,
    output word_t   q_lo,
    output logic    n,
    output logic    z
);
    logic signed [2*`ARM_MUL_WORD_W-1:0] sa;
    logic signed [2*`ARM_MUL_WORD_W-1:0] sb;
    dword_t res;
    logic   is_long;
    // SMULL and SMLAL read both operands as two's complement
    sa = {{`ARM_MUL_WORD_W{a[`ARM_MUL_WORD_W-1]}}, a};
    sb = {{`ARM_MUL_WORD_W{b[`ARM_MUL_WORD_W-1]}}, b};
    if (op == SMULL || op == SMLAL) begin
        res = dword_t'(sa * sb);
    end else begin
        res = dword_t'(a) * dword_t'(b);
    end
    // MLA adds one word, the long accumulate forms add RdHi:RdLo
    if (op == MLA) begin
        res = res + dword_t'(acc_lo);
    end else if (op == UMLAL || op == SMLAL) begin
        res = res + {acc_hi, acc_lo};
    end
    is_long = (op != MUL) && (op != MLA);
    q_hi = res[2*`ARM_MUL_WORD_W-1:`ARM_MUL_WORD_W];
    q_lo = res[`ARM_MUL_WORD_W-1:0];
    // long forms flag the double word, short forms only the low word
    if (is_long) begin
        n = res[2*`ARM_MUL_WORD_W-1];
        z = (res == '0);
    end else begin
        n = q_lo[`ARM_MUL_WORD_W-1];
        z = (q_lo == '0);
    end
endfunction

`endif

// File: testbench/arm_mul_tb.sv
`timescale 1ns/1ps
`include "arm_mul_cfg.svh"

module arm_mul_tb import arm_mul_pkg::*; ();

    // valid follows the sampling edge of start by this many rising edges
    localparam int LATENCY = `ARM_MUL_ITER + 2;
    localparam int TIMEOUT = 4 * LATENCY;

    logic    clk;
    logic    arst_n;
    logic    start;
    mul_op_e op;
    word_t   a;
    word_t   b;
    word_t   acc_hi;
    word_t   acc_lo;
    logic    busy;
    logic    valid;
    word_t   q_hi;
    word_t   q_lo;
    logic    n;
    logic    z;

    // expected results in the order the commands were issued
    mul_op_e exp_op[$];
    word_t   exp_hi[$];
    word_t   exp_lo[$];
    logic    exp_n[$];
    logic    exp_z[$];

    word_t  edge_val [4] = '{'0, '1, 32'h8000_0000, 32'h7fff_ffff};
    integer seed;
    int     errors;
    int     wait_cnt;

    `include "arm_mul_ref.svh"

    arm_mul_unit DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .acc_hi (acc_hi),
        .acc_lo (acc_lo),
        .busy   (busy),
        .valid  (valid),
        .q_hi   (q_hi),
        .q_lo   (q_lo),
        .n      (n),
        .z      (z)
    );

    always #5 clk = ~clk;

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("The unit took too long while waiting for %s", what);
        $display("Test failed");
        $fatal(1, "timeout");
    endtask

    // compare each result with the oldest outstanding command
    // q_hi only carries meaning for the long forms
    always @(negedge clk) begin
        if (valid) begin
            wait_cnt = 0;
            if (exp_op.size() == 0) begin
                $display("A result arrived although no command was outstanding");
                $display("Test failed");
                $fatal(1, "unexpected valid");
            end else begin
                check_word("q_lo", q_lo, exp_lo[0]);
                if (exp_op[0] != MUL && exp_op[0] != MLA) begin
                    check_word("q_hi", q_hi, exp_hi[0]);
                end
                check_flag("n", n, exp_n[0]);
                check_flag("z", z, exp_z[0]);
                exp_op.delete(0);
                exp_hi.delete(0);
                exp_lo.delete(0);
                exp_n.delete(0);
                exp_z.delete(0);
            end
        end else if (exp_op.size() != 0) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) report_timeout("a result");
        end
    end

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (busy) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) report_timeout("busy to fall");
        end
    endtask

    // one start pulse, returning at the falling edge after the sampling edge
    task automatic send_cmd(input mul_op_e c_op, input word_t c_a, input word_t c_b,
                            input word_t c_hi, input word_t c_lo);
        word_t e_hi;
        word_t e_lo;
        logic  e_n;
        logic  e_z;
        ref_mul(c_op, c_a, c_b, c_hi, c_lo, e_hi, e_lo, e_n, e_z);
        exp_op.push_back(c_op);
        exp_hi.push_back(e_hi);
        exp_lo.push_back(e_lo);
        exp_n.push_back(e_n);
        exp_z.push_back(e_z);
        op     = c_op;
        a      = c_a;
        b      = c_b;
        acc_hi = c_hi;
        acc_lo = c_lo;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // count rising edges up to valid while busy must stay high
    task automatic wait_result(input int elapsed);
        int edges;
        edges = elapsed;
        while (!valid) begin
            check_flag("busy", busy, 1'b1);
            @(negedge clk);
            edges++;
            if (edges > TIMEOUT) report_timeout("valid");
        end
        if (edges != LATENCY) begin
            errors++;
            $display("** Error at %0t: valid after %0d edges, expected %0d",
                     $time, edges, LATENCY);
            $display("Test failed");
            $fatal(1, "latency mismatch");
        end
    endtask

    task automatic run_cmd(input mul_op_e c_op, input word_t c_a, input word_t c_b,
                           input word_t c_hi, input word_t c_lo);
        wait_idle();
        send_cmd(c_op, c_a, c_b, c_hi, c_lo);
        wait_result(0);
    endtask

    initial begin
        seed     = 32'h689aea9a;
        errors   = 0;
        wait_cnt = 0;
        clk      = 1'b0;
        arst_n   = 1'b0;
        start    = 1'b0;
        op       = MUL;
        a        = '0;
        b        = '0;
        acc_hi   = '0;
        acc_lo   = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        // nothing may happen before the first start
        repeat (5) begin
            @(negedge clk);
            check_flag("valid", valid, 1'b0);
            check_flag("busy", busy, 1'b0);
        end
        // short forms on edge operands, then on random ones
        foreach (edge_val[i]) begin
            foreach (edge_val[j]) begin
                run_cmd(MUL, edge_val[i], edge_val[j], '0, '0);
                run_cmd(MLA, edge_val[i], edge_val[j], $random(seed), edge_val[j]);
            end
        end
        repeat (20) begin
            run_cmd((($random(seed) & 1) != 0) ? MLA : MUL, $random(seed), $random(seed),
                    $random(seed), $random(seed));
        end
        // unsigned long forms, the accumulator carries into q_hi
        run_cmd(UMULL, '1, '1, '0, '0);
        run_cmd(UMLAL, '1, '1, '0, '1);
        run_cmd(UMLAL, '1, '1, 32'h1, '1);
        repeat (20) begin
            run_cmd((($random(seed) & 1) != 0) ? UMLAL : UMULL,
                    $random(seed) | 32'h8000_0000, $random(seed) | 32'h8000_0000,
                    $random(seed), $random(seed) | 32'h8000_0000);
        end
        // signed long forms with mixed signs and a negative accumulator
        run_cmd(SMULL, 32'h8000_0000, 32'h7fff_ffff, '0, '0);
        run_cmd(SMLAL, 32'hffff_fffd, 32'h5, '1, '1);
        run_cmd(SMLAL, '1, 32'h1, '0, 32'h1);
        repeat (20) begin
            run_cmd((($random(seed) & 1) != 0) ? SMLAL : SMULL, $random(seed),
                    $random(seed) | 32'h8000_0000, $random(seed) | 32'h8000_0000,
                    $random(seed));
        end
        // a second start in the middle of a command must be dropped
        wait_idle();
        send_cmd(UMLAL, $random(seed), $random(seed), $random(seed), $random(seed));
        repeat (3) @(negedge clk);
        op    = SMULL;
        a     = $random(seed);
        b     = $random(seed);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_result(4);
        // the checker flags any valid that shows up in this window
        repeat (2 * LATENCY) @(negedge clk);
        check_flag("busy", busy, 1'b0);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rtl/arm_mul_unit.sv
`timescale 1ns/1ps
`include "arm_mul_cfg.svh"

module arm_mul_unit import arm_mul_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    start,
    input  mul_op_e op,
    input  word_t   a,
    input  word_t   b,
    input  word_t   acc_hi,
    input  word_t   acc_lo,
    output logic    busy,
    output logic    valid,
    output word_t   q_hi,
    output word_t   q_lo,
    output logic    n,
    output logic    z
);

    // command slot to Booth core
    logic   go;
    word_t  mcand;
    word_t  mplier;
    logic   is_signed;

    // command slot to accumulate stage
    logic   is_long;
    logic   add_acc;
    dword_t acc;

    // Booth core to accumulate stage
    logic   done;
    dword_t product;

    // one command is held here from start until its result is valid
    mul_cmd_reg u_cmd (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .op        (op),
        .a         (a),
        .b         (b),
        .acc_hi    (acc_hi),
        .acc_lo    (acc_lo),
        .valid     (valid),
        .busy      (busy),
        .go        (go),
        .mcand     (mcand),
        .mplier    (mplier),
        .is_signed (is_signed),
        .is_long   (is_long),
        .add_acc   (add_acc),
        .acc       (acc)
    );

    // iterative multiplier taking `ARM_MUL_ITER steps per product
    booth_radix2_core u_booth (
        .clk       (clk),
        .arst_n    (arst_n),
        .go        (go),
        .mcand     (mcand),
        .mplier    (mplier),
        .is_signed (is_signed),
        .done      (done),
        .product   (product)
    );

    // accumulate, flag and register the result
    mul_accumulate_flags u_acc (
        .clk     (clk),
        .arst_n  (arst_n),
        .done    (done),
        .product (product),
        .acc     (acc),
        .add_acc (add_acc),
        .is_long (is_long),
        .valid   (valid),
        .q_hi    (q_hi),
        .q_lo    (q_lo),
        .n       (n),
        .z       (z)
    );

endmodule

// File: rtl/mul_accumulate_flags.sv
`timescale 1ns/1ps
`include "arm_mul_cfg.svh"

module mul_accumulate_flags import arm_mul_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   done,
    input  dword_t product,
    input  dword_t acc,
    input  logic   add_acc,
    input  logic   is_long,
    output logic   valid,
    output word_t  q_hi,
    output word_t  q_lo,
    output logic   n,
    output logic   z
);

    dword_t sum;
    word_t  sum_hi;
    word_t  sum_lo;
    logic   sum_n;
    logic   sum_z;

    // the accumulate step is a plain double-word add
    // for MLA the accumulator arrives zero-extended so carries into the
    // upper word do not matter for the visible result
    always_comb begin
        if (add_acc) begin
            sum = product + acc;
        end else begin
            sum = product;
        end
    end

    assign sum_hi = sum[2*`ARM_MUL_WORD_W-1:`ARM_MUL_WORD_W];
    assign sum_lo = sum[`ARM_MUL_WORD_W-1:0];

    // flags follow the width of the destination
    // long forms look at RdHi:RdLo as one 64-bit value
    // short forms look only at the single destination word
    always_comb begin
        if (is_long) begin
            sum_n = sum_hi[`ARM_MUL_WORD_W-1];
            sum_z = (sum == '0);
        end else begin
            sum_n = sum_lo[`ARM_MUL_WORD_W-1];
            sum_z = (sum_lo == '0);
        end
    end

    // result registers
    // they change only on done and so stay stable between two valid pulses
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            q_hi  <= '0;
            q_lo  <= '0;
            n     <= 1'b0;
            z     <= 1'b0;
        end else begin
            valid <= done;
            if (done) begin
                // q_hi is always written although short forms ignore it
                q_hi <= sum_hi;
                q_lo <= sum_lo;
                n    <= sum_n;
                z    <= sum_z;
            end
        end
    end

endmodule

// File: rtl/booth_radix2_core.sv
`timescale 1ns/1ps
`include "arm_mul_cfg.svh"

module booth_radix2_core import arm_mul_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   go,
    input  word_t  mcand,
    input  word_t  mplier,
    input  logic   is_signed,
    output logic   done,
    output dword_t product
);

    // the multiplier register is one bit wider than a word
    localparam int QW    = `ARM_MUL_WORD_W + 1;
    // the partial product carries a guard bit on top of the widened multiplicand
    // so that adding or subtracting it never overflows
    localparam int AW    = `ARM_MUL_WORD_W + 2;
    localparam int CNT_W = $clog2(`ARM_MUL_ITER + 1);

    logic [AW-1:0]    m_r;
    logic [AW-1:0]    a_r;
    logic [QW-1:0]    q_r;
    logic             qm1_r;
    logic [AW-1:0]    a_sum;
    logic [AW-1:0]    m_ext;
    logic [QW-1:0]    q_ext;
    logic [CNT_W-1:0] cnt;
    logic             running;

    assign running = (cnt != '0);

    // widen both operands, by sign for SMULL and SMLAL and by zero otherwise
    // after this both look like positive or negative two's complement values
    always_comb begin
        if (is_signed) begin
            m_ext = {{2{mcand[`ARM_MUL_WORD_W-1]}}, mcand};
            q_ext = {mplier[`ARM_MUL_WORD_W-1], mplier};
        end else begin
            m_ext = {2'b00, mcand};
            q_ext = {1'b0, mplier};
        end
    end

    // radix-2 Booth recoding of the current bit pair of the multiplier
    // 01 ends a run of ones so the multiplicand is added
    // 10 starts a run of ones so the multiplicand is subtracted
    always_comb begin
        unique case ({q_r[0], qm1_r})
            2'b01:   a_sum = a_r + m_r;
            2'b10:   a_sum = a_r - m_r;
            default: a_sum = a_r;
        endcase
    end

    // iteration counter and done pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                cnt <= CNT_W'(`ARM_MUL_ITER);
            end else if (running) begin
                cnt <= cnt - 1'b1;
                // the last step is taken on this edge
                if (cnt == CNT_W'(1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    // shift register {a_r, q_r, qm1_r}
    always_ff @(posedge clk) begin
        if (go) begin
            m_r   <= m_ext;
            a_r   <= '0;
            q_r   <= q_ext;
            qm1_r <= 1'b0;
        end else if (running) begin
            // arithmetic right shift of the whole register after the add step
            a_r   <= {a_sum[AW-1], a_sum[AW-1:1]};
            q_r   <= {a_sum[0], q_r[QW-1:1]};
            qm1_r <= q_r[0];
        end
    end

    // after the last shift {a_r, q_r} holds the full product
    // only the low two words are architecturally visible
    assign product = {a_r[`ARM_MUL_WORD_W-2:0], q_r};

endmodule

// File: rtl/mul_cmd_reg.sv
`timescale 1ns/1ps
`include "arm_mul_cfg.svh"

module mul_cmd_reg import arm_mul_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    start,
    input  mul_op_e op,
    input  word_t   a,
    input  word_t   b,
    input  word_t   acc_hi,
    input  word_t   acc_lo,
    input  logic    valid,
    output logic    busy,
    output logic    go,
    output word_t   mcand,
    output word_t   mplier,
    output logic    is_signed,
    output logic    is_long,
    output logic    add_acc,
    output dword_t  acc
);

    logic   busy_r;
    logic   accept;
    logic   dec_signed;
    logic   dec_long;
    logic   dec_add;
    dword_t dec_acc;

    // the result leaves in the cycle where valid is high, so the unit already
    // reports itself idle there and a back-to-back start can be taken
    assign busy   = busy_r & ~valid;
    assign accept = start & ~busy;

    // decode the command into the three control bits used downstream
    always_comb begin
        dec_signed = 1'b0;
        dec_long   = 1'b0;
        dec_add    = 1'b0;
        unique case (op)
            MLA:     dec_add = 1'b1;
            UMULL:   dec_long = 1'b1;
            UMLAL: begin
                dec_long = 1'b1;
                dec_add  = 1'b1;
            end
            SMULL: begin
                dec_long   = 1'b1;
                dec_signed = 1'b1;
            end
            SMLAL: begin
                dec_long   = 1'b1;
                dec_signed = 1'b1;
                dec_add    = 1'b1;
            end
            default: ;
        endcase
        // long forms accumulate into RdHi:RdLo, MLA only adds a single word
        if (dec_long) begin
            dec_acc = {acc_hi, acc_lo};
        end else begin
            dec_acc = {{`ARM_MUL_WORD_W{1'b0}}, acc_lo};
        end
    end

    // control state of the command slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_r    <= 1'b0;
            go        <= 1'b0;
            is_signed <= 1'b0;
            is_long   <= 1'b0;
            add_acc   <= 1'b0;
        end else begin
            // go is high only for the cycle after start is accepted
            go <= accept;
            if (accept) begin
                busy_r    <= 1'b1;
                is_signed <= dec_signed;
                is_long   <= dec_long;
                add_acc   <= dec_add;
            end else if (valid) begin
                busy_r <= 1'b0;
            end
        end
    end

    // operands and accumulator are held for the whole operation
    always_ff @(posedge clk) begin
        if (accept) begin
            mcand  <= a;
            mplier <= b;
            acc    <= dec_acc;
        end
    end

endmodule

// File: rtl/arm_mul_pkg.sv
`include "arm_mul_cfg.svh"

package arm_mul_pkg;

    // one register-file word as seen by the multiply unit
    typedef logic [`ARM_MUL_WORD_W-1:0] word_t;

    // a pair of words, used for the full product and for the long accumulator
    // the upper word sits in the high half just as RdHi:RdLo is laid out
    typedef logic [2*`ARM_MUL_WORD_W-1:0] dword_t;

    // multiply commands accepted by the unit
    // the two low bits separate the families and bit 2 marks the signed long forms
    // MUL and MLA return a single word and keep the low half of the product
    // UMULL and UMLAL treat both operands as unsigned and return a double word
    // SMULL and SMLAL treat both operands as two's complement
    typedef enum logic [2:0] {
        // Rd = Rm * Rs
        MUL   = 3'b000,
        // Rd = Rm * Rs + Rn
        MLA   = 3'b001,
        // RdHi:RdLo = Rm * Rs, unsigned
        UMULL = 3'b010,
        // RdHi:RdLo = Rm * Rs + RdHi:RdLo, unsigned
        UMLAL = 3'b011,
        // RdHi:RdLo = Rm * Rs, signed
        SMULL = 3'b110,
        // RdHi:RdLo = Rm * Rs + RdHi:RdLo, signed
        SMLAL = 3'b111
    } mul_op_e;

    // encodings 3'b100 and 3'b101 are not used by the core
    // the command register treats them like MUL so the unit never hangs

endpackage

// File: rtl/arm_mul_cfg.svh
`ifndef ARM_MUL_CFG_SVH
`define ARM_MUL_CFG_SVH

// width of one architectural word of the core
`define ARM_MUL_WORD_W 32

// the Booth loop runs one extra step because both operands are widened by a
// sign or zero bit so that unsigned and signed operands share the same recoding
`define ARM_MUL_ITER (`ARM_MUL_WORD_W + 1)

`endif
